// ==== compile.f ====
verilog/ntm_cosine_pkg.sv
verilog/ntm_vector_accumulator.sv
verilog/ntm_integer_root.sv
verilog/ntm_integer_divider.sv
verilog/ntm_scalar_cosine_similarity_function.sv
verilog/ntm_vector_cosine_similarity_function.sv
testbench/ntm_cosine_properties.sv
testbench/ntm_cosine_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the cosine similarity testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module ntm_cosine_tb -o ntm_cosine_sim || exit 1

out=$(./obj_dir/ntm_cosine_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== testbench/ntm_cosine_properties.sv ====
/* Output strobe checks on the top level, attached by bind
   Reset values are checked one cycle after RST is seen high */

`timescale 1ns/1ns
`default_nettype none

module ntm_cosine_properties #(
  parameter int DATA_W = ntm_cosine_pkg::DEFAULT_DATA_W
) (
  input wire logic              CLK,
  input wire logic              RST,
  input wire logic              ready,
  input wire logic              out_vector_en,
  input wire logic              out_scalar_en,
  input wire logic [DATA_W-1:0] data_out
);

  // Count of failed properties
  int failures = 0;

  // READY only together with a row result
  ready_with_result: assert property (
    @(posedge CLK) disable iff (RST) ready |-> out_vector_en
  ) else begin
    $error("READY high without DATA_OUT_VECTOR_ENABLE");
    failures++;
  end

  // Single-cycle pulses
  vector_pulse: assert property (
    @(posedge CLK) disable iff (RST) out_vector_en |=> !out_vector_en
  ) else begin
    $error("DATA_OUT_VECTOR_ENABLE longer than one cycle");
    failures++;
  end

  scalar_pulse: assert property (
    @(posedge CLK) disable iff (RST) out_scalar_en |=> !out_scalar_en
  ) else begin
    $error("DATA_OUT_SCALAR_ENABLE longer than one cycle");
    failures++;
  end

  ready_pulse: assert property (
    @(posedge CLK) disable iff (RST) ready |=> !ready
  ) else begin
    $error("READY longer than one cycle");
    failures++;
  end

  // Everything quiet while in reset
  reset_values: assert property (
    @(posedge CLK) RST |=> (!ready && !out_vector_en && !out_scalar_en && data_out == '0)
  ) else begin
    $error("Outputs not cleared by reset");
    failures++;
  end

endmodule

`default_nettype wire

// ==== testbench/ntm_cosine_stimulus.txt ====
# C rows length opens a case. Each row is length lines E a b, then R expected DATA_OUT
# Signed decimal values. Expected is (dot << 14) / isqrt(|a|^2 * |b|^2), toward zero
C 2 3
E 1 1
E 2 2
E 3 3
R 16384
E 1 -1
E 2 -2
E 3 -3
R -16384
C 2 2
E 1 0
E 0 5
R 0
E 0 3
E 0 4
R 0
C 3 4
E 1 4
E 2 3
E 3 2
E 4 1
R 10922
E 2 1
E -1 1
E 0 1
E 3 1
R 9362
E -3 2
E 5 1
E -2 4
E 1 -6
R -5228
C 2 1
E 7 -3
R -16384
E -100 -250
R 16384

// ==== testbench/ntm_cosine_tb.sv ====
/* Run from the project root. Stimulus comes from testbench/ntm_cosine_stimulus.txt
   Expected row results come from the file. Rows are limited to MAX_LEN elements */

`timescale 1ns/1ns
`default_nettype none

module ntm_cosine_tb;

  import ntm_cosine_pkg::*;

  localparam int DATA_W       = DEFAULT_DATA_W;
  localparam int ACC_W        = DEFAULT_ACC_W;
  localparam int FRAC_W       = DEFAULT_FRAC_W;
  localparam int CLK_PERIOD   = 40;
  // Consume pulse is due two cycles after the later half
  localparam int ELEM_TIMEOUT = 8;
  // Root plus divide is roughly 2*ACC_W+FRAC_W cycles
  localparam int ROW_TIMEOUT  = 400;
  localparam int MAX_LEN      = 64;

  logic                     CLK;
  logic                     RST;
  logic                     start;
  logic                     ready;
  logic                     a_vector_en;
  logic                     a_scalar_en;
  logic                     b_vector_en;
  logic                     b_scalar_en;
  logic                     out_vector_en;
  logic                     out_scalar_en;
  count_t                   size_in;
  count_t                   length_in;
  logic signed [DATA_W-1:0] data_a;
  logic signed [DATA_W-1:0] data_b;
  logic        [DATA_W-1:0] data_out;

  int          fd;
  int          err_count;
  int          test_count;
  int          failed_tests;
  bit          aborted;
  int          vector_pulses = 0;
  logic [31:0] rng_state = 32'h8d9;

  // Element pairs of the current row
  int a_row [MAX_LEN];
  int b_row [MAX_LEN];

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Result strobes counted on the rising edge
  always @(posedge CLK) begin
    if (out_vector_en) begin
      vector_pulses <= vector_pulses + 1;
    end
  end

  ntm_vector_cosine_similarity_function #(
    .DATA_W(DATA_W),
    .ACC_W (ACC_W),
    .FRAC_W(FRAC_W)
  ) i_dut (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (start),
    .READY                  (ready),
    .DATA_A_IN_VECTOR_ENABLE(a_vector_en),
    .DATA_A_IN_SCALAR_ENABLE(a_scalar_en),
    .DATA_B_IN_VECTOR_ENABLE(b_vector_en),
    .DATA_B_IN_SCALAR_ENABLE(b_scalar_en),
    .DATA_OUT_VECTOR_ENABLE (out_vector_en),
    .DATA_OUT_SCALAR_ENABLE (out_scalar_en),
    .SIZE_IN                (size_in),
    .LENGTH_IN              (length_in),
    .DATA_A_IN              (data_a),
    .DATA_B_IN              (data_b),
    .DATA_OUT               (data_out)
  );

  bind ntm_vector_cosine_similarity_function ntm_cosine_properties #(
    .DATA_W(DATA_W)
  ) i_properties (
    .CLK          (CLK),
    .RST          (RST),
    .ready        (READY),
    .out_vector_en(DATA_OUT_VECTOR_ENABLE),
    .out_scalar_en(DATA_OUT_SCALAR_ENABLE),
    .data_out     (DATA_OUT)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // LCG for the A to B skew
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Next data line of the file
  // Comments and blank lines skipped
  task automatic read_record(output byte tag, output int v1, output int v2, output bit found);
    string line;
    int    code;
    found = 1'b0;
    tag   = 8'h00;
    v1    = 0;
    v2    = 0;
    while (!found && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
        tag   = line.getc(0);
        code  = $sscanf(line.substr(1, line.len() - 1), "%d %d", v1, v2);
        found = 1'b1;
      end
    end
  endtask

  task automatic clear_strobes();
    a_vector_en = 1'b0;
    a_scalar_en = 1'b0;
    b_vector_en = 1'b0;
    b_scalar_en = 1'b0;
  endtask

  // Junk on the data lines while no strobe is up
  task automatic scramble_data();
    logic [31:0] junk;
    junk   = lcg_next();
    data_a = junk[DATA_W-1:0];
    data_b = junk[31 -: DATA_W];
  endtask

  // First element of a row uses the vector strobes
  task automatic drive_half(input bit is_a, input bit first, input int value);
    if (is_a) begin
      data_a      = DATA_W'(value);
      a_vector_en = first;
      a_scalar_en = !first;
    end else begin
      data_b      = DATA_W'(value);
      b_vector_en = first;
      b_scalar_en = !first;
    end
  endtask

  // One element with a random skew of 0 to 2 cycles between the halves
  task automatic send_element(input int test_id, input int row, input int elem,
                              input int a, input int b, output bit ok);
    logic [31:0] rnd;
    bit          a_first;
    int unsigned skew;
    int          cycles;
    rnd     = lcg_next();
    a_first = rnd[16];
    skew    = (rnd >> 20) % 3;
    drive_half(a_first, elem == 0, a_first ? a : b);
    if (skew != 0) begin
      @(negedge CLK);
      clear_strobes();
      scramble_data();
      repeat (skew - 1) @(negedge CLK);
    end
    drive_half(!a_first, elem == 0, a_first ? b : a);
    @(negedge CLK);
    clear_strobes();
    scramble_data();
    // One cycle after the later strobe
    cycles = 1;
    while (!out_scalar_en && cycles < ELEM_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    ok = out_scalar_en;
    if (ok) begin
      assert (cycles == 2) else begin
        $display("Fail DATA_OUT_SCALAR_ENABLE test %0d row %0d elem %0d: delay %h expected %h",
                 test_id, row, elem, cycles, 2);
        err_count++;
      end
    end else begin
      $display("Timeout waiting for DATA_OUT_SCALAR_ENABLE in test %0d row %0d element %0d",
               test_id, row, elem);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row and case sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int test_id, input int row, input bit last_row, input int len,
                         input int expected, output bit ok);
    logic [DATA_W-1:0] want;
    int                elem;
    int                cycles;
    ok   = 1'b1;
    want = DATA_W'(expected);
    for (elem = 0; elem < len && ok; elem++) begin
      send_element(test_id, row, elem, a_row[elem], b_row[elem], ok);
    end
    if (ok) begin
      cycles = 0;
      while (!out_vector_en && cycles < ROW_TIMEOUT) begin
        assert (!ready) else begin
          $display("READY rose without a row result in test %0d row %0d", test_id, row);
          err_count++;
        end
        @(negedge CLK);
        cycles++;
      end
      ok = out_vector_en;
      if (!ok) begin
        $display("Timeout waiting for DATA_OUT_VECTOR_ENABLE in test %0d row %0d", test_id, row);
      end
    end
    if (ok) begin
      assert (data_out == want) else begin
        $display("Fail DATA_OUT test %0d row %0d: got %h expected %h",
                 test_id, row, data_out, want);
        err_count++;
      end
      // READY only with the final row
      assert (ready == last_row) else begin
        $display("Fail READY test %0d row %0d: got %h expected %h",
                 test_id, row, ready, last_row);
        err_count++;
      end
      @(negedge CLK);
      assert (!out_vector_en && !ready) else begin
        $display("Result strobe held past one cycle in test %0d row %0d", test_id, row);
        err_count++;
      end
    end
  endtask

  task automatic run_case(input int test_id, input int rows, input int len, output bit ok);
    byte tag;
    int  v1;
    int  v2;
    bit  found;
    int  row;
    int  elem;
    int  pulses_before;
    ok            = 1'b1;
    pulses_before = vector_pulses;
    size_in       = count_t'(rows);
    length_in     = count_t'(len);
    start         = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    for (row = 0; row < rows && ok; row++) begin
      for (elem = 0; elem < len && ok; elem++) begin
        read_record(tag, v1, v2, found);
        ok          = found && (tag == "E");
        a_row[elem] = v1;
        b_row[elem] = v2;
      end
      if (ok) begin
        read_record(tag, v1, v2, found);
        ok = found && (tag == "R");
      end
      if (!ok) begin
        $display("Stimulus file ends early or is malformed in test %0d row %0d", test_id, row);
      end else begin
        run_row(test_id, row, row == rows - 1, len, v1, ok);
      end
    end
    if (ok) begin
      assert (vector_pulses - pulses_before == rows) else begin
        $display("Fail DATA_OUT_VECTOR_ENABLE count test %0d: got %h expected %h",
                 test_id, vector_pulses - pulses_before, rows);
        err_count++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    byte tag;
    int  v1;
    int  v2;
    bit  found;
    bit  more;
    bit  case_ok;
    int  errs_before;
    CLK          = 1'b0;
    RST          = 1'b1;
    start        = 1'b0;
    size_in      = '0;
    length_in    = '0;
    data_a       = '0;
    data_b       = '0;
    err_count    = 0;
    test_count   = 0;
    failed_tests = 0;
    clear_strobes();
    fd      = $fopen("testbench/ntm_cosine_stimulus.txt", "r");
    aborted = (fd == 0);
    if (aborted) begin
      $display("Cannot open testbench/ntm_cosine_stimulus.txt");
    end
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    more = !aborted;
    while (more) begin
      read_record(tag, v1, v2, found);
      if (!found) begin
        more = 1'b0;
      end else if (tag != "C" || v1 < 1 || v2 < 1 || v2 > MAX_LEN) begin
        $display("Malformed case header in the stimulus file");
        aborted = 1'b1;
        more    = 1'b0;
      end else begin
        errs_before = err_count;
        run_case(test_count + 1, v1, v2, case_ok);
        test_count++;
        if (case_ok && err_count == errs_before) begin
          $display("Test %0d: %0d rows x %0d elements ok", test_count, v1, v2);
        end else begin
          failed_tests++;
          $display("Test %0d: %0d rows x %0d elements failed", test_count, v1, v2);
        end
        if (!case_ok) begin
          aborted = 1'b1;
          more    = 1'b0;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    // Bound property failures count as check errors
    err_count = err_count + i_dut.i_properties.failures;
    $display("Tests run %0d, failed %0d, check errors %0d", test_count, failed_tests, err_count);
    if (!aborted && err_count == 0 && failed_tests == 0 && test_count > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ntm_cosine_pkg.sv ====
/* Shared widths, counter type and FSM encodings for the cosine similarity engine
   Width defaults only. Every module takes the real widths from the top level */

`default_nettype none

package ntm_cosine_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Width defaults
  ////////////////////////////////////////////////////////////////////////////

  // Element and result width
  localparam int DEFAULT_DATA_W = 16;
  // Dot product and norm sums
  localparam int DEFAULT_ACC_W  = 40;
  // Fraction bits of the fixed-point result
  localparam int DEFAULT_FRAC_W = 14;

  // Row and element counts
  typedef logic [15:0] count_t;

  ////////////////////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////////////////////

  // Top level sequencer
  typedef enum logic [1:0] {STARTER, INPUT_VECTOR, INPUT_SCALAR, ENDER} vector_state_t;

  // Per-row scalar engine
  typedef enum logic [2:0] {IDLE, ACCUMULATE, ROOT, DIVIDE, DONE} scalar_state_t;

endpackage

`default_nettype wire

// ==== verilog/ntm_integer_divider.sv ====
/* Unsigned restoring divide, one quotient bit per cycle, ACC_W+FRAC_W cycles
   Zero divisor gives a zero quotient. The remainder is not brought out */

`timescale 1ns/1ns
`default_nettype none

module ntm_integer_divider #(
  parameter int ACC_W  = ntm_cosine_pkg::DEFAULT_ACC_W,
  parameter int FRAC_W = ntm_cosine_pkg::DEFAULT_FRAC_W
) (
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      start,
  input  wire logic [ACC_W+FRAC_W-1:0]   dividend,
  input  wire logic [ACC_W-1:0]          divisor,
  output logic                           done,
  output logic      [ACC_W+FRAC_W-1:0]   quotient
);

  localparam int QUO_W = ACC_W + FRAC_W;
  localparam int CNT_W = $clog2(QUO_W + 1);

  logic             busy_q;
  logic [CNT_W-1:0] steps_q;

  // Dividend shifts out the top as quotient bits shift in
  logic [QUO_W-1:0] quo_q;
  logic [ACC_W-1:0] rem_q;
  logic [ACC_W-1:0] div_q;

  logic [ACC_W:0] trial;
  logic           fits;

  assign trial = {rem_q, quo_q[QUO_W-1]};
  assign fits  = (trial >= {1'b0, div_q});

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      steps_q <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy_q  <= 1'b1;
        steps_q <= CNT_W'(QUO_W);
      end else if (busy_q) begin
        steps_q <= steps_q - 1'b1;
        if (steps_q == CNT_W'(1)) begin
          busy_q <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      quo_q <= dividend;
      rem_q <= '0;
      div_q <= divisor;
    end else if (busy_q) begin
      // Restore by keeping the unsubtracted trial
      rem_q <= fits ? ACC_W'(trial - {1'b0, div_q}) : trial[ACC_W-1:0];
      quo_q <= {quo_q[QUO_W-2:0], fits};
    end
  end

  // All-ones pattern from a zero divisor is masked
  assign quotient = (div_q == '0) ? '0 : quo_q;

endmodule

`default_nettype wire

// ==== verilog/ntm_integer_root.sv ====
/* Floor square root, two radicand bits per cycle, done after ACC_W cycles
   A start while busy restarts the root. root holds until the next start */

`timescale 1ns/1ns
`default_nettype none

module ntm_integer_root #(
  parameter int ACC_W = ntm_cosine_pkg::DEFAULT_ACC_W
) (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  wire logic               start,
  input  wire logic [2*ACC_W-1:0] radicand,
  output logic                    done,
  output logic      [ACC_W-1:0]   root
);

  localparam int CNT_W = $clog2(ACC_W + 1);

  // Control
  logic             busy_q;
  logic [CNT_W-1:0] steps_q;

  // Datapath
  logic [2*ACC_W-1:0] rad_q;
  logic [ACC_W-1:0]   rem_q;
  logic [ACC_W-1:0]   root_q;

  // Trial remainder against 4*root+1
  logic [ACC_W+1:0] trial;
  logic [ACC_W+1:0] test;
  logic             fits;

  // Next two radicand bits join the remainder
  assign trial = {rem_q, rad_q[2*ACC_W-1 -: 2]};
  assign test  = {1'b0, root_q[ACC_W-2:0], 2'b01};
  assign fits  = (trial >= test);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      steps_q <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy_q  <= 1'b1;
        steps_q <= CNT_W'(ACC_W);
      end else if (busy_q) begin
        steps_q <= steps_q - 1'b1;
        // Final root digit this cycle
        if (steps_q == CNT_W'(1)) begin
          busy_q <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      rad_q  <= radicand;
      rem_q  <= '0;
      root_q <= '0;
    end else if (busy_q) begin
      rad_q  <= rad_q << 2;
      // Top remainder bits only overflow after the last digit
      rem_q  <= fits ? ACC_W'(trial - test) : trial[ACC_W-1:0];
      root_q <= {root_q[ACC_W-2:0], fits};
    end
  end

  assign root = root_q;

endmodule

`default_nettype wire

// ==== verilog/ntm_scalar_cosine_similarity_function.sv ====
/* One row per start. start comes with the first element, last with the final one
   Result is (dot << FRAC_W) / isqrt(|a|^2 * |b|^2), truncated toward zero */

`timescale 1ns/1ns
`default_nettype none

module ntm_scalar_cosine_similarity_function #(
  parameter int DATA_W = ntm_cosine_pkg::DEFAULT_DATA_W,
  parameter int ACC_W  = ntm_cosine_pkg::DEFAULT_ACC_W,
  parameter int FRAC_W = ntm_cosine_pkg::DEFAULT_FRAC_W
) (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     start,
  input  wire logic                     data_in_enable,
  input  wire logic                     last,
  input  wire logic signed [DATA_W-1:0] data_a,
  input  wire logic signed [DATA_W-1:0] data_b,
  output logic                          done,
  output logic signed      [DATA_W-1:0] result
);

  import ntm_cosine_pkg::*;

  scalar_state_t state_q;

  // Accumulator sums
  logic signed [ACC_W-1:0] dot;
  logic        [ACC_W-1:0] norm_a;
  logic        [ACC_W-1:0] norm_b;

  // Root and divider hookup
  logic                      root_start_q;
  logic                      root_done;
  logic [2*ACC_W-1:0]        radicand;
  logic [ACC_W-1:0]          root;
  logic                      div_start_q;
  logic                      div_done;
  logic [ACC_W+FRAC_W-1:0]   dividend;
  logic [ACC_W+FRAC_W-1:0]   quotient;

  // Sign handling
  logic              dot_neg;
  logic [ACC_W-1:0]  dot_mag;
  logic [DATA_W-1:0] quot_low;

  // Sums stay put after the last element so these remain valid
  assign radicand = {{ACC_W{1'b0}}, norm_a} * {{ACC_W{1'b0}}, norm_b};
  assign dot_neg  = dot[ACC_W-1];
  assign dot_mag  = dot_neg ? -dot : dot;
  assign dividend = {dot_mag, {FRAC_W{1'b0}}};
  assign quot_low = DATA_W'(quotient);

  ////////////////////////////////////////////////////////////////////////////
  // Row sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= IDLE;
      root_start_q <= 1'b0;
      div_start_q  <= 1'b0;
    end else begin
      root_start_q <= 1'b0;
      div_start_q  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            // Single-element row goes straight to the root
            if (data_in_enable && last) begin
              root_start_q <= 1'b1;
              state_q      <= ROOT;
            end else begin
              state_q <= ACCUMULATE;
            end
          end
        end
        ACCUMULATE: begin
          // Sums settle on the same edge the root start rises
          if (data_in_enable && last) begin
            root_start_q <= 1'b1;
            state_q      <= ROOT;
          end
        end
        ROOT: begin
          if (root_done) begin
            div_start_q <= 1'b1;
            state_q     <= DIVIDE;
          end
        end
        DIVIDE: begin
          if (div_done) begin
            state_q <= DONE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Signed result lands together with the DONE state
  always_ff @(posedge CLK) begin
    if (state_q == DIVIDE && div_done) begin
      result <= dot_neg ? -quot_low : quot_low;
    end
  end

  assign done = (state_q == DONE);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath blocks
  ////////////////////////////////////////////////////////////////////////////

  ntm_vector_accumulator #(
    .DATA_W(DATA_W),
    .ACC_W (ACC_W)
  ) i_accumulator (
    .CLK   (CLK),
    .RST   (RST),
    .clear (start),
    .enable(data_in_enable),
    .data_a(data_a),
    .data_b(data_b),
    .dot   (dot),
    .norm_a(norm_a),
    .norm_b(norm_b)
  );

  ntm_integer_root #(
    .ACC_W(ACC_W)
  ) i_root (
    .CLK     (CLK),
    .RST     (RST),
    .start   (root_start_q),
    .radicand(radicand),
    .done    (root_done),
    .root    (root)
  );

  ntm_integer_divider #(
    .ACC_W (ACC_W),
    .FRAC_W(FRAC_W)
  ) i_divider (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start_q),
    .dividend(dividend),
    .divisor (root),
    .done    (div_done),
    .quotient(quotient)
  );

endmodule

`default_nettype wire

// ==== verilog/ntm_vector_accumulator.sv ====
/* Sums wrap silently. ACC_W must exceed 2*DATA_W plus log2 of the row length
   clear with enable in the same cycle restarts the sums from that element */

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_accumulator #(
  parameter int DATA_W = ntm_cosine_pkg::DEFAULT_DATA_W,
  parameter int ACC_W  = ntm_cosine_pkg::DEFAULT_ACC_W
) (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     clear,
  input  wire logic                     enable,
  input  wire logic signed [DATA_W-1:0] data_a,
  input  wire logic signed [DATA_W-1:0] data_b,
  output logic signed      [ACC_W-1:0]  dot,
  output logic             [ACC_W-1:0]  norm_a,
  output logic             [ACC_W-1:0]  norm_b
);

  // Full-precision products of the current element pair
  logic signed [2*DATA_W-1:0] prod_ab;
  logic signed [2*DATA_W-1:0] sq_a;
  logic signed [2*DATA_W-1:0] sq_b;

  // Products widened to the accumulator
  logic signed [ACC_W-1:0] prod_ab_ext;
  logic        [ACC_W-1:0] sq_a_ext;
  logic        [ACC_W-1:0] sq_b_ext;

  assign prod_ab = data_a * data_b;
  assign sq_a    = data_a * data_a;
  assign sq_b    = data_b * data_b;

  // Sign extension for the dot term
  assign prod_ab_ext = ACC_W'(prod_ab);
  // Squares are never negative
  assign sq_a_ext    = ACC_W'(sq_a);
  assign sq_b_ext    = ACC_W'(sq_b);

  ////////////////////////////////////////////////////////////////////////////
  // Running sums
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot    <= '0;
      norm_a <= '0;
      norm_b <= '0;
    end else if (clear) begin
      // New row, first element may come with the clear
      dot    <= enable ? prod_ab_ext : '0;
      norm_a <= enable ? sq_a_ext : '0;
      norm_b <= enable ? sq_b_ext : '0;
    end else if (enable) begin
      dot    <= dot + prod_ab_ext;
      norm_a <= norm_a + sq_a_ext;
      norm_b <= norm_b + sq_b_ext;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ntm_vector_cosine_similarity_function.sv ====
/* No back-pressure. Next element only after DATA_OUT_SCALAR_ENABLE of the last
   SIZE_IN and LENGTH_IN are sampled on START and must both be nonzero */

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_cosine_similarity_function #(
  parameter int DATA_W = ntm_cosine_pkg::DEFAULT_DATA_W,
  parameter int ACC_W  = ntm_cosine_pkg::DEFAULT_ACC_W,
  parameter int FRAC_W = ntm_cosine_pkg::DEFAULT_FRAC_W
) (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     START,
  output logic                          READY,
  input  wire logic                     DATA_A_IN_VECTOR_ENABLE,
  input  wire logic                     DATA_A_IN_SCALAR_ENABLE,
  input  wire logic                     DATA_B_IN_VECTOR_ENABLE,
  input  wire logic                     DATA_B_IN_SCALAR_ENABLE,
  output logic                          DATA_OUT_VECTOR_ENABLE,
  output logic                          DATA_OUT_SCALAR_ENABLE,
  input  wire ntm_cosine_pkg::count_t   SIZE_IN,
  input  wire ntm_cosine_pkg::count_t   LENGTH_IN,
  input  wire logic signed [DATA_W-1:0] DATA_A_IN,
  input  wire logic signed [DATA_W-1:0] DATA_B_IN,
  output logic             [DATA_W-1:0] DATA_OUT
);

  import ntm_cosine_pkg::*;

  vector_state_t state_q;

  // Sizes sampled on START
  count_t size_q;
  count_t length_q;
  count_t row_idx_q;
  count_t elem_idx_q;

  // Element halves, each on its own strobe
  logic                     a_held_q;
  logic                     b_held_q;
  logic signed [DATA_W-1:0] a_q;
  logic signed [DATA_W-1:0] b_q;

  // Strobes seen only in the matching input state
  logic a_strobe;
  logic b_strobe;
  logic elem_last;
  logic row_last;

  // Engine interface
  logic                     eng_start_q;
  logic                     eng_enable_q;
  logic                     eng_last_q;
  logic                     eng_done;
  logic signed [DATA_W-1:0] eng_result;

  assign a_strobe = (state_q == INPUT_VECTOR) ? DATA_A_IN_VECTOR_ENABLE :
                    (state_q == INPUT_SCALAR) ? DATA_A_IN_SCALAR_ENABLE : 1'b0;
  assign b_strobe = (state_q == INPUT_VECTOR) ? DATA_B_IN_VECTOR_ENABLE :
                    (state_q == INPUT_SCALAR) ? DATA_B_IN_SCALAR_ENABLE : 1'b0;

  assign elem_last = (elem_idx_q == length_q - count_t'(1));
  assign row_last  = (row_idx_q == size_q - count_t'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Row and element sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q                <= STARTER;
      size_q                 <= '0;
      length_q               <= '0;
      row_idx_q              <= '0;
      elem_idx_q             <= '0;
      a_held_q               <= 1'b0;
      b_held_q               <= 1'b0;
      eng_start_q            <= 1'b0;
      eng_enable_q           <= 1'b0;
      eng_last_q             <= 1'b0;
      READY                  <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      DATA_OUT               <= '0;
    end else begin
      // Single-cycle strobes
      eng_start_q            <= 1'b0;
      eng_enable_q           <= 1'b0;
      READY                  <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      if (a_strobe) begin
        a_held_q <= 1'b1;
      end
      if (b_strobe) begin
        b_held_q <= 1'b1;
      end
      case (state_q)
        STARTER: begin
          if (START) begin
            size_q     <= SIZE_IN;
            length_q   <= LENGTH_IN;
            row_idx_q  <= '0;
            elem_idx_q <= '0;
            a_held_q   <= 1'b0;
            b_held_q   <= 1'b0;
            state_q    <= INPUT_VECTOR;
          end
        end
        INPUT_VECTOR, INPUT_SCALAR: begin
          // Consume once both halves are held
          if (a_held_q && b_held_q) begin
            a_held_q               <= 1'b0;
            b_held_q               <= 1'b0;
            eng_start_q            <= (state_q == INPUT_VECTOR);
            eng_enable_q           <= 1'b1;
            eng_last_q             <= elem_last;
            DATA_OUT_SCALAR_ENABLE <= 1'b1;
            elem_idx_q             <= elem_last ? '0 : elem_idx_q + count_t'(1);
            state_q                <= elem_last ? ENDER : INPUT_SCALAR;
          end
        end
        ENDER: begin
          // Engine latency varies with nothing to count here
          if (eng_done) begin
            DATA_OUT               <= eng_result;
            DATA_OUT_VECTOR_ENABLE <= 1'b1;
            if (row_last) begin
              READY     <= 1'b1;
              row_idx_q <= '0;
              state_q   <= STARTER;
            end else begin
              row_idx_q <= row_idx_q + count_t'(1);
              state_q   <= INPUT_VECTOR;
            end
          end
        end
        default: begin
          state_q <= STARTER;
        end
      endcase
    end
  end

  // Payload follows the strobes
  always_ff @(posedge CLK) begin
    if (a_strobe) begin
      a_q <= DATA_A_IN;
    end
    if (b_strobe) begin
      b_q <= DATA_B_IN;
    end
  end

  ntm_scalar_cosine_similarity_function #(
    .DATA_W(DATA_W),
    .ACC_W (ACC_W),
    .FRAC_W(FRAC_W)
  ) i_scalar (
    .CLK           (CLK),
    .RST           (RST),
    .start         (eng_start_q),
    .data_in_enable(eng_enable_q),
    .last          (eng_last_q),
    .data_a        (a_q),
    .data_b        (b_q),
    .done          (eng_done),
    .result        (eng_result)
  );

endmodule

`default_nettype wire
